//--- Bender.yml
package:
  name: pbkdf_engine

sources:
  - target: rtl
    files:
      - hdl/pbkdf_pkg.sv
      - hdl/sha256_core.sv
      - hdl/hash_round_counter.sv
      - hdl/pbkdf_fsm.sv
      - hdl/pbkdf_datapath.sv
      - hdl/pbkdf_engine.sv
  - target: test
    files:
      - verification/pbkdf_clock_gen.sv
      - verification/pbkdf_checker.sv
      - verification/pbkdf_assertions.sv
      - verification/pbkdf_engine_tb.sv

//--- all.f
hdl/pbkdf_pkg.sv
hdl/sha256_core.sv
hdl/hash_round_counter.sv
hdl/pbkdf_fsm.sv
hdl/pbkdf_datapath.sv
hdl/pbkdf_engine.sv
verification/pbkdf_clock_gen.sv
verification/pbkdf_checker.sv
verification/pbkdf_assertions.sv
verification/pbkdf_engine_tb.sv

//--- hdl/hash_round_counter.sv
// Round counter for each compression and salt-block counter for each job, shared by core and datapath
`default_nettype none
`timescale 1ns/1ps

module hash_round_counter (
	input  logic                   pbkdf_clk,
	input  logic                   reset,
	input  logic                   start,      // Restart rounds
	input  logic                   capture,    // New job accepted
	input  logic                   done,       // Compression finished
	input  pbkdf_pkg::pbkdf_step_t step,
	output logic [5:0]             round,
	output logic                   last_salt,  // Fourth block just finished
	output logic [1:0]             salt_index
);
	import pbkdf_pkg::*;

	always_ff @(posedge pbkdf_clk) begin
		if (reset) begin
			round      <= 6'd0;
			salt_index <= 2'd0;
		end else begin
			if (start)
				round <= 6'd0;
			else if (round != 6'(rounds - 1))
				round <= round + 6'd1; // Parks at 63 between compressions
			if (capture)
				salt_index <= 2'd0;
			else if (done && step == salt_outer)
				salt_index <= salt_index + 2'd1;
		end
	end

	assign last_salt = done && (step == salt_outer) && (salt_index == 2'(salt_blocks - 1));

endmodule

`default_nettype wire

//--- hdl/pbkdf_datapath.sv
// Work item and intermediate hash storage, builds each chaining state and padded message block
`default_nettype none
`timescale 1ns/1ps

module pbkdf_datapath (
	input  logic                   pbkdf_clk,
	input  logic                   reset,
	input  logic                   capture,
	input  logic                   load,
	input  logic                   done,
	input  pbkdf_pkg::pbkdf_work_t job,
	input  pbkdf_pkg::pbkdf_step_t step,
	input  logic [1:0]             salt_index,
	input  pbkdf_pkg::sha_state_t  digest,
	output pbkdf_pkg::sha_state_t  chain,
	output pbkdf_pkg::sha_block_t  message,
	output pbkdf_pkg::pbkdf_block_t blk
);
	import pbkdf_pkg::*;

	pbkdf_work_t work;         // Captured header
	sha_state_t  key_hash;     // Hash of the header
	sha_state_t  inner_hash;   // Inner HMAC state
	sha_state_t  outer_hash;   // Outer HMAC state
	sha_state_t  scratch;      // Midstate or inner digest
	sha_state_t  next_chain;
	sha_block_t  next_message;
	logic [31:0] blk_num;      // 1-based PBKDF2 block count

	assign blk_num = {30'd0, salt_index} + 32'd1;

	always_comb begin
		next_chain   = sha_iv;
		next_message = work.head;
		case (step)
			key_head: ; // Defaults
			key_tail: begin
				next_chain   = scratch;
				next_message = {hdr_tail_pad, work.nonce, work.tail};
			end
			ipad_key: next_message = {{8{ipad_word}}, key_hash ^ {8{ipad_word}}};
			ipad_msg: next_chain = scratch;
			opad_key: next_message = {{8{opad_word}}, key_hash ^ {8{opad_word}}};
			salt_inner: begin
				next_chain   = inner_hash;
				next_message = {salt_pad, blk_num, work.nonce, work.tail};
			end
			salt_outer: begin
				next_chain   = outer_hash;
				next_message = {digest_pad, scratch};
			end
			default: ;
		endcase
	end

	always_ff @(posedge pbkdf_clk) begin
		if (capture)
			work <= job;
		if (load) begin
			chain   <= next_chain;   // Held for the whole compression
			message <= next_message;
		end
		if (done) begin
			case (step)
				key_head, ipad_key, salt_inner: scratch <= digest;
				key_tail: key_hash   <= digest;
				ipad_msg: inner_hash <= digest;
				opad_key: outer_hash <= digest;
				default: ;
			endcase
		end
	end

	always_ff @(posedge pbkdf_clk) begin
		if (reset) begin
			blk <= '0;
		end else if (done && step == salt_outer) begin
			blk.index <= salt_index;
			blk.hash  <= digest; // Stays put until the next block
		end
	end

endmodule

`default_nettype wire

//--- hdl/pbkdf_engine.sv
// Top level of the PBKDF2-HMAC-SHA256 front end, takes header jobs and returns four salt blocks each
`default_nettype none
`timescale 1ns/1ps

module pbkdf_engine (
	input  logic                    pbkdf_clk,
	input  logic                    reset,
	input  logic                    job_req,
	input  pbkdf_pkg::pbkdf_work_t  job,
	output logic                    job_ack,
	output logic                    blk_req,
	output pbkdf_pkg::pbkdf_block_t blk,
	input  logic                    blk_ack
);
	import pbkdf_pkg::*;

	logic        capture, load, start, done, last_salt;
	pbkdf_step_t step;
	logic [5:0]  round;
	logic [1:0]  salt_index;
	sha_state_t  chain, digest;
	sha_block_t  message;

	pbkdf_fsm u_fsm (
		.pbkdf_clk, .reset,
		.job_req, .job_ack, .blk_req, .blk_ack,
		.done, .last_salt, .capture, .step, .load, .start
	);

	hash_round_counter u_counter (
		.pbkdf_clk, .reset,
		.start, .capture, .done, .step,
		.round, .last_salt, .salt_index
	);

	pbkdf_datapath u_datapath (
		.pbkdf_clk, .reset,
		.capture, .load, .done, .job, .step, .salt_index, .digest,
		.chain, .message, .blk
	);

	sha256_core u_core (
		.pbkdf_clk, .reset,
		.start, .round, .chain, .message,
		.digest, .done
	);

endmodule

`default_nettype wire

//--- hdl/pbkdf_fsm.sv
// Job sequencer, walks the thirteen compressions and runs the job and block handshakes
`default_nettype none
`timescale 1ns/1ps

module pbkdf_fsm (
	input  logic                   pbkdf_clk,
	input  logic                   reset,
	input  logic                   job_req,
	output logic                   job_ack,
	output logic                   blk_req,
	input  logic                   blk_ack,
	input  logic                   done,      // From core
	input  logic                   last_salt, // From counter, valid with done
	output logic                   capture,   // Latch work item
	output pbkdf_pkg::pbkdf_step_t step,
	output logic                   load,      // Latch next chain and block
	output logic                   start
);
	import pbkdf_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_compress,
		st_wait_ack, // blk_req up, waiting for sink
		st_release   // Waiting for blk_ack to fall
	} fsm_state_t;

	fsm_state_t state;
	logic       final_blk; // Current block is the job's last

	// Accept only once the previous job_ack has fallen
	assign capture = (state == st_idle) && job_req && !job_ack;

	always_ff @(posedge pbkdf_clk) begin
		if (reset) begin
			state     <= st_idle;
			step      <= key_head;
			start     <= 1'b0;
			load      <= 1'b0;
			blk_req   <= 1'b0;
			final_blk <= 1'b0;
		end else begin
			start <= 1'b0; // Single-cycle strobes
			load  <= 1'b0;
			case (state)
				st_idle: begin
					if (capture) begin
						step  <= key_head;
						start <= 1'b1;
						load  <= 1'b1;
						state <= st_compress;
					end
				end
				st_compress: begin
					if (done) begin
						if (step == salt_outer) begin
							blk_req   <= 1'b1; // Block is latched in this same edge
							final_blk <= last_salt;
							state     <= st_wait_ack;
						end else begin
							step  <= pbkdf_step_t'(step + 3'd1); // Steps run in enum order
							start <= 1'b1;
							load  <= 1'b1;
						end
					end
				end
				st_wait_ack: begin
					if (blk_ack) begin
						blk_req <= 1'b0;
						state   <= st_release;
					end
				end
				st_release: begin
					if (!blk_ack) begin
						if (final_blk) begin
							state <= st_idle;
						end else begin
							step  <= salt_inner; // Next salt block
							start <= 1'b1;
							load  <= 1'b1;
							state <= st_compress;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Job side runs alongside the compressions
	always_ff @(posedge pbkdf_clk) begin
		if (reset)
			job_ack <= 1'b0;
		else if (capture)
			job_ack <= 1'b1;
		else if (!job_req)
			job_ack <= 1'b0; // Source released, drop ack
	end

endmodule

`default_nettype wire

//--- hdl/pbkdf_pkg.sv
// Shared widths, SHA-256 constants, padding words and port structs, imported by all engine RTL
`default_nettype none

package pbkdf_pkg;

	localparam int hash_w      = 256; // SHA-256 state width
	localparam int block_w     = 512; // Message block width
	localparam int rounds      = 64;  // Rounds per compression
	localparam int salt_blocks = 4;   // Output blocks per job

	typedef logic [hash_w/32-1:0][31:0]  sha_state_t; // Word 0 is H0, at the low end
	typedef logic [block_w/32-1:0][31:0] sha_block_t; // Word 0 is W0, at the low end

	// Standard SHA-256 initial state, H0 in the low word
	localparam sha_state_t sha_iv = {
		32'h5be0cd19, 32'h1f83d9ab, 32'h9b05688c, 32'h510e527f,
		32'ha54ff53a, 32'h3c6ef372, 32'hbb67ae85, 32'h6a09e667
	};

	localparam logic [31:0] ipad_word = 32'h3636_3636; // HMAC inner pad
	localparam logic [31:0] opad_word = 32'h5c5c_5c5c; // HMAC outer pad

	// Words 4..15 after the 16 header tail bytes, 80 bytes total
	localparam logic [11:0][31:0] hdr_tail_pad = {
		32'h0000_0280,                    // Length 640 bits
		{10{32'h0000_0000}},
		32'h8000_0000                     // Stop bit
	};

	// Words 5..15 of a salt block, 64 + 80 + 4 bytes
	localparam logic [10:0][31:0] salt_pad = {
		32'h0000_04a0,                    // Length 1184 bits
		{9{32'h0000_0000}},
		32'h8000_0000
	};

	// Words 8..15 after a digest hashed on top of a key block
	localparam logic [7:0][31:0] digest_pad = {
		32'h0000_0300,                    // Length 768 bits
		{6{32'h0000_0000}},
		32'h8000_0000
	};

	typedef enum logic [2:0] {
		key_head,   // Header bytes 0..63
		key_tail,   // Header bytes 64..79 plus padding
		ipad_key,   // Key xor ipad
		ipad_msg,   // Header bytes 0..63 on top of inner key
		opad_key,   // Key xor opad
		salt_inner, // Salt block on top of inner hash
		salt_outer  // Inner digest on top of outer hash
	} pbkdf_step_t;

	typedef struct packed {
		sha_block_t       head;  // First 64 header bytes
		logic [2:0][31:0] tail;  // Next 12 header bytes
		logic [31:0]      nonce; // Last header word
	} pbkdf_work_t;

	typedef struct packed {
		logic [$clog2(salt_blocks)-1:0] index; // Block number, 0 based
		sha_state_t                     hash;
	} pbkdf_block_t;

endpackage

`default_nettype wire

//--- hdl/sha256_core.sv
// Iterative SHA-256 compression, one round per clock, timed by the external round counter
`default_nettype none
`timescale 1ns/1ps

module sha256_core (
	input  logic                  pbkdf_clk,
	input  logic                  reset,
	input  logic                  start,   // Begin a compression
	input  logic [5:0]            round,   // Current round from counter
	input  pbkdf_pkg::sha_state_t chain,   // Chaining state, stable until done
	input  pbkdf_pkg::sha_block_t message, // Message block, valid from round 0
	output pbkdf_pkg::sha_state_t digest,  // Valid while done is high
	output logic                  done
);
	import pbkdf_pkg::*;

	localparam logic [31:0] round_k [rounds] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
		32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
		32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
		32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
		32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
		32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	logic        busy;             // Rounds in progress
	sha_state_t  vars_q, vars;     // Working registers a..h as words 0..7
	sha_block_t  sched_q, sched;   // Rolling sixteen-word schedule
	logic [31:0] big_s0, big_s1;
	logic [31:0] ch, maj, t1, t2;
	logic [31:0] w_next;

	function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	always_comb begin
		vars  = (round == 6'd0) ? chain : vars_q;     // Round 0 starts from chaining state
		sched = (round == 6'd0) ? message : sched_q;  // and from the fresh block
		big_s1 = rotr(vars[4], 6) ^ rotr(vars[4], 11) ^ rotr(vars[4], 25);
		ch     = (vars[4] & vars[5]) ^ (~vars[4] & vars[6]);
		t1     = vars[7] + big_s1 + ch + round_k[round] + sched[0];
		big_s0 = rotr(vars[0], 2) ^ rotr(vars[0], 13) ^ rotr(vars[0], 22);
		maj    = (vars[0] & vars[1]) ^ (vars[0] & vars[2]) ^ (vars[1] & vars[2]);
		t2     = big_s0 + maj;
		// W[t+16] from W[t+14], W[t+9], W[t+1], W[t]
		w_next = (rotr(sched[14], 17) ^ rotr(sched[14], 19) ^ (sched[14] >> 10))
			+ sched[9]
			+ (rotr(sched[1], 7) ^ rotr(sched[1], 18) ^ (sched[1] >> 3))
			+ sched[0];
	end

	always_ff @(posedge pbkdf_clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= busy && (round == 6'(rounds - 1)); // One cycle after round 63
			if (start)
				busy <= 1'b1;
			else if (round == 6'(rounds - 1))
				busy <= 1'b0;
		end
	end

	always_ff @(posedge pbkdf_clk) begin
		if (busy) begin
			vars_q <= {vars[6], vars[5], vars[4], vars[3] + t1, // e = d + t1
				vars[2], vars[1], vars[0], t1 + t2};            // a = t1 + t2
			sched_q <= {w_next, sched[15:1]};                   // Shift window down
		end
	end

	always_comb begin
		for (int i = 0; i < hash_w / 32; i++)
			digest[i] = chain[i] + vars_q[i]; // Feed-forward add
	end

endmodule

`default_nettype wire

//--- verification/pbkdf_assertions.sv
// Handshake protocol assertions, bound into every pbkdf_engine instance
`default_nettype none
`timescale 1ns/1ps

module pbkdf_assertions (
	input logic                    pbkdf_clk,
	input logic                    reset,
	input logic                    job_req,
	input logic                    job_ack,
	input logic                    blk_req,
	input logic                    blk_ack,
	input pbkdf_pkg::pbkdf_block_t blk
);
	// Block held while the sink has not answered
	blk_stable: assert property (@(posedge pbkdf_clk) disable iff (reset)
		(blk_req && !blk_ack) |=> (blk == $past(blk)))
		else $error("blk changed while blk_req was pending");

	// Next request only once the previous ack is gone
	req_after_ack: assert property (@(posedge pbkdf_clk) disable iff (reset)
		$rose(blk_req) |-> !$past(blk_ack))
		else $error("blk_req rose while blk_ack was high");

	// Ack rose on the edge where job_req was seen high
	ack_needs_req: assert property (@(posedge pbkdf_clk) disable iff (reset)
		$rose(job_ack) |-> $past(job_req))
		else $error("job_ack rose without job_req");

endmodule

bind pbkdf_engine pbkdf_assertions u_assertions (
	.pbkdf_clk, .reset, .job_req, .job_ack, .blk_req, .blk_ack, .blk
);

`default_nettype wire

//--- verification/pbkdf_checker.sv
// Block monitor for the engine testbench, compares each new block with its expected hash
`default_nettype none
`timescale 1ns/1ps

module pbkdf_checker #(
	parameter int n_blocks = 16
) (
	input  logic                             pbkdf_clk,
	input  logic                             reset,
	input  logic                             blk_req,
	input  pbkdf_pkg::pbkdf_block_t          blk,
	input  logic [n_blocks-1:0][255:0]       expected, // In arrival order
	output int                               blk_count,
	output int                               error_count
);
	import pbkdf_pkg::*;

	logic req_seen; // blk_req level at the previous sample

	initial begin
		blk_count   = 0;
		error_count = 0;
		req_seen    = 1'b0;
	end

	// DUT outputs move on the rising edge, so sample on the falling one
	always @(negedge pbkdf_clk) begin
		if (reset) begin
			req_seen = 1'b0;
		end else begin
			if (blk_req && !req_seen) begin // New block offered
				if (blk_count >= n_blocks) begin
					error_count++;
					$display("Extra block arrived at %0t after all %0d expected blocks",
						$time, n_blocks);
				end else begin
					if (blk.index !== 2'(blk_count % salt_blocks)) begin
						error_count++;
						$display("[FAIL] %0t blk.index expected %0d actual %0d",
							$time, blk_count % salt_blocks, blk.index);
					end
					if (blk.hash !== expected[blk_count]) begin
						error_count++;
						$display("[FAIL] %0t blk.hash expected %h actual %h",
							$time, expected[blk_count], blk.hash);
					end
				end
				blk_count++;
			end
			req_seen = blk_req;
		end
	end

endmodule

`default_nettype wire

//--- verification/pbkdf_clock_gen.sv
// Testbench clock and reset source, 100 ns clock with reset held for the first four cycles
`default_nettype none
`timescale 1ns/1ps

module pbkdf_clock_gen (
	input  logic ext_reset, // Extra reset pulse from the testbench
	output logic pbkdf_clk,
	output logic reset
);
	logic por_reset; // Power-on part

	initial begin
		pbkdf_clk = 1'b0;
		por_reset = 1'b1;
		repeat (4) @(posedge pbkdf_clk);
		@(negedge pbkdf_clk);
		por_reset = 1'b0; // Released away from the sampling edge
	end

	always #50 pbkdf_clk = ~pbkdf_clk; // 100 ns period

	assign reset = por_reset | ext_reset;

endmodule

`default_nettype wire

//--- verification/pbkdf_engine_tb.sv
// Engine testbench top, reads headers from the input file, drives jobs and acks, reports the result
`default_nettype none
`timescale 1ns/1ps

module pbkdf_engine_tb;
	import pbkdf_pkg::*;

	localparam int n_items     = 3;
	localparam int n_blocks    = 16;   // Three jobs plus the re-run after reset
	localparam int max_delay   = 20;   // Ack delay limit in cycles
	localparam int limit_cyc   = 5 * 13 * 70 + n_blocks * 2 * max_delay + 400;
	localparam int kat_base    = 20 * n_items; // Known-answer block after the items

	localparam logic [31:0] k_table [64] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
		32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
		32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
		32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
		32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
		32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	localparam sha_state_t init_state = {
		32'h5be0cd19, 32'h1f83d9ab, 32'h9b05688c, 32'h510e527f,
		32'ha54ff53a, 32'h3c6ef372, 32'hbb67ae85, 32'h6a09e667
	};

	logic                        pbkdf_clk, reset, ext_reset;
	logic                        job_req, job_ack, blk_req, blk_ack;
	pbkdf_work_t                 job;
	pbkdf_block_t                blk;
	logic [n_blocks-1:0][255:0]  exp_hash;
	logic [31:0]                 mem [kat_base + 24]; // Items, then KAT block and digest
	int                          blk_count, chk_errors, tb_errors;
	integer                      seed;

	pbkdf_clock_gen u_clock (.ext_reset, .pbkdf_clk, .reset);

	pbkdf_engine DUT (
		.pbkdf_clk, .reset, .job_req, .job, .job_ack, .blk_req, .blk, .blk_ack
	);

	pbkdf_checker #(.n_blocks(n_blocks)) u_checker (
		.pbkdf_clk, .reset, .blk_req, .blk, .expected(exp_hash),
		.blk_count, .error_count(chk_errors)
	);

	function automatic logic [31:0] ror32(input logic [31:0] x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// Plain FIPS 180-4 compression, word 0 is H0 and W0
	function automatic sha_state_t compress(input sha_state_t h, input sha_block_t m);
		logic [31:0] w [64];
		logic [31:0] a, b, c, d, e, f, g, hh, s0, s1, t1, t2;
		sha_state_t  r;
		for (int i = 0; i < 16; i++)
			w[i] = m[i];
		for (int i = 16; i < 64; i++) begin
			s0 = ror32(w[i-15], 7) ^ ror32(w[i-15], 18) ^ (w[i-15] >> 3);
			s1 = ror32(w[i-2], 17) ^ ror32(w[i-2], 19) ^ (w[i-2] >> 10);
			w[i] = w[i-16] + s0 + w[i-7] + s1;
		end
		{hh, g, f, e, d, c, b, a} = h;
		for (int i = 0; i < 64; i++) begin
			s1 = ror32(e, 6) ^ ror32(e, 11) ^ ror32(e, 25);
			t1 = hh + s1 + ((e & f) ^ (~e & g)) + k_table[i] + w[i];
			s0 = ror32(a, 2) ^ ror32(a, 13) ^ ror32(a, 22);
			t2 = s0 + ((a & b) ^ (a & c) ^ (b & c));
			{hh, g, f, e, d, c, b, a} = {g, f, e, d + t1, c, b, a, t1 + t2};
		end
		r = {hh, g, f, e, d, c, b, a};
		for (int i = 0; i < 8; i++)
			r[i] = r[i] + h[i]; // Feed-forward
		return r;
	endfunction

	// PBKDF2-HMAC-SHA256, password and salt both the 80-byte header, one iteration
	task automatic compute_expected(input int item, input int slot);
		sha_block_t b;
		sha_state_t key, inner, outer, u;
		int         base;
		base = 20 * item;
		for (int i = 0; i < 16; i++)
			b[i] = mem[base + i];
		key = compress(init_state, b);
		b = '0;
		for (int i = 0; i < 4; i++)
			b[i] = mem[base + 16 + i];
		b[4]  = 32'h8000_0000;
		b[15] = 32'd640; // 80 bytes
		key = compress(key, b);
		b = '0;
		for (int i = 0; i < 16; i++)
			b[i] = (i < 8 ? key[i % 8] : 32'd0) ^ 32'h3636_3636;
		inner = compress(init_state, b);
		for (int i = 0; i < 16; i++)
			b[i] = mem[base + i];
		inner = compress(inner, b); // ipad then first 64 header bytes
		for (int i = 0; i < 16; i++)
			b[i] = (i < 8 ? key[i % 8] : 32'd0) ^ 32'h5c5c_5c5c;
		outer = compress(init_state, b);
		for (int blk_no = 0; blk_no < salt_blocks; blk_no++) begin
			b = '0;
			for (int i = 0; i < 4; i++)
				b[i] = mem[base + 16 + i];
			b[4]  = blk_no + 1;       // INT(i), big endian
			b[5]  = 32'h8000_0000;
			b[15] = 32'd1184;         // 64 + 80 + 4 bytes
			u = compress(inner, b);
			b = '0;
			for (int i = 0; i < 8; i++)
				b[i] = u[i];
			b[8]  = 32'h8000_0000;
			b[15] = 32'd768;          // 64 + 32 bytes
			exp_hash[slot * salt_blocks + blk_no] = compress(outer, b);
		end
	endtask

	task automatic check_outputs_low(input string when);
		if (job_ack !== 1'b0 || blk_req !== 1'b0) begin
			tb_errors++;
			$display("At %0t job_ack or blk_req was not low %s", $time, when);
		end
	endtask

	// Drive a work item and hold job_req until the engine acks
	task automatic present_job(input int item);
		int base;
		base = 20 * item;
		@(negedge pbkdf_clk);
		for (int i = 0; i < 16; i++)
			job.head[i] = mem[base + i];
		for (int i = 0; i < 3; i++)
			job.tail[i] = mem[base + 16 + i];
		job.nonce = mem[base + 19];
		job_req   = 1'b1;
		do @(negedge pbkdf_clk); while (!job_ack);
	endtask

	// Four-phase job handshake on the falling edge
	task automatic issue_job(input int item);
		present_job(item);
		job_req = 1'b0;
		do @(negedge pbkdf_clk); while (job_ack);
	endtask

	task automatic wait_blocks(input int n);
		while (blk_count < n)
			@(negedge pbkdf_clk);
	endtask

	// Sink side, random delay before each ack edge
	initial begin
		blk_ack = 1'b0;
		forever begin
			@(negedge pbkdf_clk);
			if (blk_req && !reset) begin
				repeat ($unsigned($random(seed)) % (max_delay + 1)) @(negedge pbkdf_clk);
				blk_ack = 1'b1;
				do @(negedge pbkdf_clk); while (blk_req);
				repeat ($unsigned($random(seed)) % (max_delay + 1)) @(negedge pbkdf_clk);
				blk_ack = 1'b0;
			end
		end
	end

	initial begin
		#(limit_cyc * 100);
		$display("Timeout, the jobs did not complete within %0d cycles", limit_cyc);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		sha_block_t kat_blk;
		sha_state_t kat_dig;
		seed      = 32'hb62d1a7d;
		job_req   = 1'b0;
		job       = '0;
		ext_reset = 1'b0;
		tb_errors = 0;
		exp_hash  = '0;
		$readmemh("verification/pbkdf_input.txt", mem);
		for (int i = 0; i < 16; i++)
			kat_blk[i] = mem[kat_base + i];
		for (int i = 0; i < 8; i++)
			kat_dig[i] = mem[kat_base + 16 + i];
		if (compress(init_state, kat_blk) !== kat_dig) begin
			tb_errors++;
			$display("Reference SHA-256 model disagrees with the known answer in the file");
		end
		for (int j = 0; j < n_items; j++)
			compute_expected(j, j);
		compute_expected(1, 3); // Re-run of item 1 after the reset
		do begin
			@(negedge pbkdf_clk);
			check_outputs_low("during power-on reset");
		end while (reset);
		repeat (10) begin
			@(negedge pbkdf_clk);
			check_outputs_low("while idle before the first job");
		end
		for (int j = 0; j < n_items; j++)
			issue_job(j); // Back to back, each waits for the engine to go idle
		wait_blocks(3 * salt_blocks);
		present_job(1); // job_req kept high so job_ack is still up at reset
		repeat (150) @(negedge pbkdf_clk); // Inside the key phase, before any block
		ext_reset = 1'b1;
		repeat (4) @(negedge pbkdf_clk);
		check_outputs_low("while reset was held in the middle of a job");
		job_req   = 1'b0;
		ext_reset = 1'b0;
		if (blk_count != 3 * salt_blocks) begin
			tb_errors++;
			$display("Aborted job delivered blocks, count is %0d", blk_count);
		end
		issue_job(1);
		wait_blocks(n_blocks);
		repeat (100) @(negedge pbkdf_clk);
		if (blk_count != n_blocks) begin
			tb_errors++;
			$display("Expected %0d blocks in total but saw %0d", n_blocks, blk_count);
		end
		$display("Blocks %0d, block errors %0d, other errors %0d",
			blk_count, chk_errors, tb_errors);
		if (chk_errors + tb_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/pbkdf_input.txt
// Three 80-byte headers, 20 words each: version, prev hash x8, merkle x8, time, bits, nonce
// Then a SHA-256 known-answer pair: one padded "abc" block (16 words), its digest H0..H7
00000002 1c3f9a60 77b2e01d 5d9c4a12 0e8f37b4 a1d2c3e4 9b8a7f66 4e3d2c1b 00000000
6a5f4e3d 2c1b0a99 88776655 44332211 f0e1d2c3 b4a59687 78695a4b 3c2d1e0f 5201f3a4 1b0e1a2f 0000a3c1
00000002 8d4e2f1a 3b6c9d0e 1f2a3b4c 5d6e7f80 91a2b3c4 d5e6f708 192a3b4c 00000000
deadbeef 01234567 89abcdef fedcba98 76543210 0badf00d cafebabe 13579bdf 5201f45c 1b0e1a2f 7f3e9d22
00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
4a5e1e4b aab89f3a 32518a88 c31bc87f 618f7667 3e2cc77a b2127b7a fdeda33b 4e0f3b2a 1e0ffff0 ffffffff
61626380 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000018
ba7816bf 8f01cfea 414140de 5dae2223 b00361a3 96177a9c b410ff61 f20015ad
